/* source/board_pkg.sv */
package board_pkg;

    localparam int w_value = 16;   // Counter width shared by all blocks

    // Operation key positions
    localparam int key_inc  = 0;
    localparam int key_dec  = 1;
    localparam int key_load = 2;
    localparam int key_clr  = 3;

    // 640x480 timing in pixels and lines
    localparam int h_visible = 640;
    localparam int h_front   = 16;
    localparam int h_sync    = 96;
    localparam int h_back    = 48;
    localparam int v_visible = 480;
    localparam int v_front   = 10;
    localparam int v_sync    = 2;
    localparam int v_back    = 33;

    // Segment a in bit 7, dot in bit 0 stays dark
    function automatic logic [7:0] hex_to_segments(input logic [3:0] nibble);
        case (nibble)
            4'h0: return 8'b1111_1100;
            4'h1: return 8'b0110_0000;
            4'h2: return 8'b1101_1010;
            4'h3: return 8'b1111_0010;
            4'h4: return 8'b0110_0110;
            4'h5: return 8'b1011_0110;
            4'h6: return 8'b1011_1110;
            4'h7: return 8'b1110_0000;
            4'h8: return 8'b1111_1110;
            4'h9: return 8'b1111_0110;
            4'ha: return 8'b1110_1110;
            4'hb: return 8'b0011_1110;  // Lower case b
            4'hc: return 8'b1001_1100;
            4'hd: return 8'b0111_1010;  // Lower case d
            4'he: return 8'b1001_1110;
            default: return 8'b1000_1110;  // F
        endcase
    endfunction

endpackage

/* source/counter_control.sv */
`timescale 1ns/1ps

module counter_control import board_pkg::*; #(
    parameter w_key = 8,
    parameter w_sw  = 7
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [w_key   - 1:0] key,    // Raw key levels
    input  logic [w_sw    - 1:0] sw,     // Load source
    output logic [w_value - 1:0] value
);

    logic [3:0] key_meta;   // First sync stage
    logic [3:0] key_sync;   // Stable level
    logic [3:0] key_prev;   // Level one cycle ago
    logic [3:0] press;      // Single-cycle strobes
    logic [3:0] cmd;        // Winning command, indexed like the keys

    // Only the four operation keys are watched
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            key_meta <= '0;
            key_sync <= '0;
            key_prev <= '0;
        end else begin
            key_meta <= key[key_clr:key_inc];
            key_sync <= key_meta;
            key_prev <= key_sync;
        end
    end

    assign press = key_sync & ~key_prev;   // Rising edge only

    // Clear beats load beats inc beats dec
    always_comb begin
        cmd = '0;
        if (press[key_clr])       cmd[key_clr]  = 1'b1;
        else if (press[key_load]) cmd[key_load] = 1'b1;
        else if (press[key_inc])  cmd[key_inc]  = 1'b1;
        else if (press[key_dec])  cmd[key_dec]  = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            value <= '0;
        else if (cmd[key_clr])
            value <= '0;
        else if (cmd[key_load])
            value <= w_value'(sw);       // Zero extended
        else if (cmd[key_inc])
            value <= value + 1'b1;       // Wraps at all ones
        else if (cmd[key_dec])
            value <= value - 1'b1;       // Wraps at zero
    end

    // A press lands exactly one command in the register
    assert property (@(posedge clk) disable iff (!rst_n)
        (press != 4'b0000) |=> (value == '0) || (value == w_value'($past(sw)))
            || (value == $past(value) + 1'b1) || (value == $past(value) - 1'b1));
    // No strobe means the value holds
    assert property (@(posedge clk) disable iff (!rst_n)
        (press == 4'b0000) |=> (value == $past(value)));

endmodule

/* source/seven_segment_scan.sv */
`timescale 1ns/1ps

module seven_segment_scan import board_pkg::*; #(
    parameter clk_mhz = 50,
    parameter w_sw    = 7,
    parameter w_digit = 6
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [w_value - 1:0] value,
    input  logic [w_sw    - 1:0] sw,
    output logic [          7:0] abcdefgh,
    output logic [w_digit - 1:0] digit      // One-hot, digit 0 is bit 0
);

    localparam int ms_cycles = clk_mhz * 1000;          // Clocks per millisecond
    localparam int w_ms      = $clog2(ms_cycles);
    localparam int w_idx     = (w_digit > 1) ? $clog2(w_digit) : 1;

    logic [w_ms  - 1:0] ms_cnt;
    logic               ms_tick;
    logic [w_idx - 1:0] idx;       // Binary copy of the enabled digit
    logic [        7:0] sw_byte;
    logic [        3:0] nibble;

    assign ms_tick = (ms_cnt == w_ms'(ms_cycles - 1));

    always_ff @(posedge clk) begin
        if (!rst_n || ms_tick)
            ms_cnt <= '0;
        else
            ms_cnt <= ms_cnt + 1'b1;
    end

    // Step to the next digit once per millisecond
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            digit <= w_digit'(1);
            idx   <= '0;
        end else if (ms_tick) begin
            digit <= {digit[w_digit - 2:0], digit[w_digit - 1]};  // Rotate left
            idx   <= (idx == w_idx'(w_digit - 1)) ? '0 : idx + 1'b1;
        end
    end

    assign sw_byte = 8'(sw);

    // Nibble follows the enabled digit with no lag
    always_comb begin
        case (idx)
            w_idx'(0): nibble = value[3:0];
            w_idx'(1): nibble = value[7:4];
            w_idx'(2): nibble = value[11:8];
            w_idx'(3): nibble = value[15:12];
            w_idx'(4): nibble = sw_byte[3:0];
            w_idx'(5): nibble = {1'b0, sw_byte[6:4]};
            default:   nibble = 4'h0;
        endcase
    end

    assign abcdefgh = hex_to_segments(nibble);

    // Enable stays one-hot and tracks the nibble select
    assert property (@(posedge clk) disable iff (!rst_n)
        $onehot(digit) && (digit == (w_digit'(1) << idx)));

endmodule

/* source/vga_display.sv */
`timescale 1ns/1ps

module vga_display import board_pkg::*; #(
    parameter clk_mhz = 50
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [w_value - 1:0] value,
    output logic                 hsync,   // Active low
    output logic                 vsync,   // Active low
    output logic [          3:0] red,
    output logic [          3:0] green,
    output logic [          3:0] blue
);

    localparam int pix_div = clk_mhz / 25;                    // Clocks per pixel
    localparam int w_div   = (pix_div > 1) ? $clog2(pix_div) : 1;
    localparam int h_total = h_visible + h_front + h_sync + h_back;  // 800
    localparam int v_total = v_visible + v_front + v_sync + v_back;  // 525

    logic [w_div - 1:0] div_cnt;
    logic               pix_en;
    logic [        9:0] x;          // Pixel in line
    logic [        9:0] y;          // Line in frame
    logic               h_pulse;
    logic               v_pulse;
    logic               visible;

    // Stuck at zero for a 25 MHz clock, so every cycle is a pixel
    assign pix_en = (div_cnt == w_div'(pix_div - 1));

    always_ff @(posedge clk) begin
        if (!rst_n || pix_en)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            x <= '0;
            y <= '0;
        end else if (pix_en) begin
            if (x == 10'(h_total - 1)) begin
                x <= '0;
                y <= (y == 10'(v_total - 1)) ? '0 : y + 1'b1;  // New frame
            end else begin
                x <= x + 1'b1;
            end
        end
    end

    // Pixels 656..751, lines 490..491
    assign h_pulse = (x >= 10'(h_visible + h_front))
                  && (x <  10'(h_visible + h_front + h_sync));
    assign v_pulse = (y >= 10'(v_visible + v_front))
                  && (y <  10'(v_visible + v_front + v_sync));
    assign visible = (x < 10'(h_visible)) && (y < 10'(v_visible));

    // Syncs and colors share one register stage
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hsync <= 1'b1;
            vsync <= 1'b1;
            red   <= '0;
            green <= '0;
            blue  <= '0;
        end else begin
            hsync <= ~h_pulse;
            vsync <= ~v_pulse;
            red   <= (visible && x[5]) ? value[3:0]  : 4'd0;  // Vertical bars
            green <= visible           ? value[7:4]  : 4'd0;
            blue  <= (visible && y[5]) ? value[11:8] : 4'd0;  // Horizontal bands
        end
    end

    // No color may reach the pins during a sync pulse
    assert property (@(posedge clk) disable iff (!rst_n)
        (!hsync || !vsync) |-> ({red, green, blue} == 12'd0));

endmodule

/* source/top.sv */
`timescale 1ns/1ps

module top import board_pkg::*; #(
    parameter clk_mhz = 50,
    parameter w_key   = 8,
    parameter w_sw    = 7,
    parameter w_led   = 16,
    parameter w_digit = 6
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [w_key   - 1:0] key,       // Active high, unsynchronized
    input  logic [w_sw    - 1:0] sw,
    output logic [w_led   - 1:0] led,
    output logic [          7:0] abcdefgh,  // Active high segments
    output logic [w_digit - 1:0] digit,     // One-hot enable
    output logic                 hsync,
    output logic                 vsync,
    output logic [          3:0] red,
    output logic [          3:0] green,
    output logic [          3:0] blue
);

    logic [w_value - 1:0] value;   // Shared counter value

    counter_control #(
        .w_key ( w_key ),
        .w_sw  ( w_sw  )
    ) u_counter_control (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .key   ( key   ),
        .sw    ( sw    ),
        .value ( value )
    );

    assign led = w_led'(value);    // Widen or cut to the LED count

    seven_segment_scan #(
        .clk_mhz ( clk_mhz ),
        .w_sw    ( w_sw    ),
        .w_digit ( w_digit )
    ) u_seven_segment_scan (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .value    ( value    ),
        .sw       ( sw       ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

    vga_display #(
        .clk_mhz ( clk_mhz )
    ) u_vga_display (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .value ( value ),
        .hsync ( hsync ),
        .vsync ( vsync ),
        .red   ( red   ),
        .green ( green ),
        .blue  ( blue  )
    );

endmodule

/* source/board_specific_top.sv */
`timescale 1ns/1ps

module board_specific_top #(
    parameter clk_mhz = 50,
    parameter w_key   = 8,
    parameter w_sw    = 8,   // Top switch is the reset
    parameter w_led   = 16,
    parameter w_digit = 6
) (
    input                  CLK,

    input  [w_key   - 1:0] KEY_N,     // Low when pressed
    input  [w_sw    - 1:0] SW,

    output [w_led   - 1:0] LED,

    output [          7:0] ABCDEFGH,
    output [w_digit - 1:0] DIGIT_N,   // Low enables a digit

    input                  UART_RX,   // Not used here
    output                 UART_TX,

    inout  [         22:2] GPIO_P1,   // VGA connector
    inout  [         22:2] GPIO_P2    // Free header
);

    wire                  rst_n;
    wire [w_sw    - 2:0] top_sw;     // All switches below the reset one
    wire [w_digit - 1:0] digit;
    wire                  vga_hs;
    wire                  vga_vs;
    wire [          3:0] vga_red;
    wire [          3:0] vga_green;
    wire [          3:0] vga_blue;

    assign rst_n  = ~SW[w_sw - 1];   // Switch up holds reset
    assign top_sw = SW[w_sw - 2:0];

    top #(
        .clk_mhz ( clk_mhz  ),
        .w_key   ( w_key    ),
        .w_sw    ( w_sw - 1 ),
        .w_led   ( w_led    ),
        .w_digit ( w_digit  )
    ) u_top (
        .clk      ( CLK       ),
        .rst_n    ( rst_n     ),
        .key      ( ~KEY_N    ),  // Pressed key reads as 1
        .sw       ( top_sw    ),
        .led      ( LED       ),
        .abcdefgh ( ABCDEFGH  ),
        .digit    ( digit     ),
        .hsync    ( vga_hs    ),
        .vsync    ( vga_vs    ),
        .red      ( vga_red   ),
        .green    ( vga_green ),
        .blue     ( vga_blue  )
    );

    assign DIGIT_N = ~digit;
    assign UART_TX = 1'b1;           // Idle line

    // Sync pins
    assign GPIO_P1[3]  = vga_vs;
    assign GPIO_P1[4]  = vga_hs;
    // Red, MSB first
    assign GPIO_P1[6]  = vga_red[3];
    assign GPIO_P1[7]  = vga_red[2];
    assign GPIO_P1[8]  = vga_red[1];
    assign GPIO_P1[9]  = vga_red[0];
    // Green
    assign GPIO_P1[11] = vga_green[3];
    assign GPIO_P1[12] = vga_green[2];
    assign GPIO_P1[13] = vga_green[1];
    assign GPIO_P1[14] = vga_green[0];
    // Blue
    assign GPIO_P1[16] = vga_blue[3];
    assign GPIO_P1[17] = vga_blue[2];
    assign GPIO_P1[18] = vga_blue[1];
    assign GPIO_P1[19] = vga_blue[0];

endmodule

/* test/tb_board_specific_top.sv */
`timescale 1ns/1ps

module tb_board_specific_top import board_pkg::*; ();

    localparam int w_digit  = 6;
    localparam int h_total  = h_visible + h_front + h_sync + h_back;
    localparam int v_total  = v_visible + v_front + v_sync + v_back;
    localparam int ms_ticks = 25 * 1000;                    // Digit step at 25 MHz
    localparam int watchdog_cycles = 16 * 10 + 12 * ms_ticks + 5 * h_total * v_total + 5000;
    localparam logic [3:0] k_inc  = 4'(1 << key_inc);
    localparam logic [3:0] k_dec  = 4'(1 << key_dec);
    localparam logic [3:0] k_load = 4'(1 << key_load);
    localparam logic [3:0] k_clr  = 4'(1 << key_clr);

    logic                 clk;
    logic [          7:0] key_n;
    logic [          7:0] sw;          // Bit 7 is the board reset
    logic                 uart_rx;
    wire  [         15:0] led;
    wire  [          7:0] abcdefgh;
    wire  [w_digit - 1:0] digit_n;
    wire                  uart_tx;
    wire  [         22:2] gpio_p1;
    wire  [         22:2] gpio_p2;
    int                   errors;
    int                   n_tests;
    int                   n_failed;
    logic [          3:0] row_keys[$];
    logic [          6:0] row_sw[$];
    logic [w_value - 1:0] row_exp[$];
    logic [w_value - 1:0] model;       // Expected counter value
    // Reference patterns with segment a in bit 7
    logic [7:0] seg_ref [16] = '{8'hfc, 8'h60, 8'hda, 8'hf2, 8'h66, 8'hb6, 8'hbe, 8'he0,
                                 8'hfe, 8'hf6, 8'hee, 8'h3e, 8'h9c, 8'h7a, 8'h9e, 8'h8e};

    board_specific_top #(.clk_mhz(25), .w_key(8), .w_sw(8), .w_led(16), .w_digit(w_digit))
    u_board_specific_top (
        .CLK(clk), .KEY_N(key_n), .SW(sw), .LED(led), .ABCDEFGH(abcdefgh),
        .DIGIT_N(digit_n), .UART_RX(uart_rx), .UART_TX(uart_tx),
        .GPIO_P1(gpio_p1), .GPIO_P2(gpio_p2)
    );

    always #20 clk = ~clk;   // 25 MHz

    // Clear, then load, then inc, then dec
    function automatic logic [w_value - 1:0] next_value(input logic [w_value - 1:0] v,
                                                        input logic [3:0] k, input logic [6:0] s);
        if (k[key_clr])  return '0;
        if (k[key_load]) return {9'd0, s};
        if (k[key_inc])  return v + 16'd1;
        if (k[key_dec])  return v - 16'd1;
        return v;
    endfunction

    function automatic logic sync_pin(input int which);
        return (which == 1) ? gpio_p1[3] : gpio_p1[4];   // 1 is vsync
    endfunction

    // Red, green, blue as seen on the connector
    function automatic logic [11:0] color_pins();
        return {gpio_p1[6], gpio_p1[7], gpio_p1[8], gpio_p1[9], gpio_p1[11], gpio_p1[12],
                gpio_p1[13], gpio_p1[14], gpio_p1[16], gpio_p1[17], gpio_p1[18], gpio_p1[19]};
    endfunction

    task automatic add_row(input logic [3:0] keys, input logic [6:0] swv);
        model = next_value(model, keys, swv);
        row_keys.push_back(keys);
        row_sw.push_back(swv);
        row_exp.push_back(model);
    endtask

    task automatic check_value(input string name, input logic [w_value - 1:0] got, exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_segments(input string name, input logic [7:0] got, exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_digit(input string name, input logic [w_digit - 1:0] got, exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_color(input string name, input logic [3:0] got, exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    // Levels and cycle counts of the sync lines
    task automatic check_sync(input string name, input int got, exp);
        if (got != exp) begin
            errors++;
            $display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic end_test(input string name, input int first_err);
        n_tests++;
        if (errors != first_err) n_failed++;
        $display("%-36s %s", name, (errors == first_err) ? "ok" : "failed");
    endtask

    // Low time and period in clocks between two falling edges
    task automatic measure_sync(input int which, output int low_len, output int period);
        low_len = 0;
        @(negedge clk);
        while (sync_pin(which) !== 1'b1) @(negedge clk);
        while (sync_pin(which) === 1'b1) @(negedge clk);
        while (sync_pin(which) === 1'b0) begin
            low_len++;
            @(negedge clk);
        end
        period = low_len;
        while (sync_pin(which) === 1'b1) begin
            period++;
            @(negedge clk);
        end
    endtask

    // Walks one frame pixel by pixel from the first vsync line
    task automatic scan_frame(input logic [w_value - 1:0] v);
        int          x;
        int          y;
        logic        vis;
        logic [11:0] exp_rgb;
        logic [11:0] got_rgb;
        @(negedge clk);
        while (sync_pin(1) !== 1'b1) @(negedge clk);
        while (sync_pin(1) === 1'b1) @(negedge clk);
        x = 0;
        y = v_visible + v_front;                // Pulse starts at pixel 0 of line 490
        for (int n = 0; n < h_total * v_total; n++) begin
            vis = (x < h_visible) && (y < v_visible);   // Sync windows lie outside
            exp_rgb[11:8] = (vis && x[5]) ? v[3:0]  : 4'h0;
            exp_rgb[7:4]  = vis           ? v[7:4]  : 4'h0;
            exp_rgb[3:0]  = (vis && y[5]) ? v[11:8] : 4'h0;
            got_rgb = color_pins();
            if (got_rgb !== exp_rgb) begin
                $display("Wrong color at pixel %0d of line %0d", x, y);
                check_color("red", got_rgb[11:8], exp_rgb[11:8]);
                check_color("green", got_rgb[7:4], exp_rgb[7:4]);
                check_color("blue", got_rgb[3:0], exp_rgb[3:0]);
                break;
            end
            x = (x == h_total - 1) ? 0 : x + 1;
            if (x == 0) y = (y == v_total - 1) ? 0 : y + 1;
            @(negedge clk);
        end
    endtask

    initial begin
        #(watchdog_cycles * 40);
        $display("Timeout: the run took longer than all tests together should");
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int                   first_err;
        int                   low_len;
        int                   period;
        int                   d;
        logic [          3:0] nib;
        logic [w_digit - 1:0] exp_digit;
        clk      = 1'b0;
        key_n    = '1;          // No key down
        sw       = 8'h80;       // Reset switch up
        uart_rx  = 1'b1;
        errors   = 0;
        n_tests  = 0;
        n_failed = 0;
        model    = '0;
        void'($urandom(12));
        add_row(k_inc, 7'h00);
        add_row(k_inc, 7'h00);
        add_row(k_dec, 7'h00);
        add_row(k_dec, 7'h00);
        add_row(k_dec, 7'h00);                  // Wraps below zero
        add_row(k_inc, 7'h00);                  // And back
        add_row(k_load, 7'($urandom()));
        add_row(k_inc, 7'h00);
        add_row(k_load, 7'($urandom()));
        add_row(k_clr | k_load, 7'($urandom()));  // Clear wins
        add_row(k_load | k_inc, 7'($urandom()));  // Load wins
        add_row(k_inc | k_dec, 7'h00);          // Inc wins
        add_row(k_clr, 7'h00);
        add_row(k_dec, 7'h00);
        add_row(k_dec, 7'h00);                  // Ends at 0xfffe with every nibble lit
        repeat (2) @(posedge clk);
        #5 sw[7] = 1'b0;
        @(negedge clk);
        first_err = errors;
        check_value("LED", led, 16'h0000);
        check_digit("DIGIT_N", digit_n, ~w_digit'(1));
        check_sync("GPIO_P1[4] hsync level", int'(gpio_p1[4]), 1);
        check_sync("GPIO_P1[3] vsync level", int'(gpio_p1[3]), 1);
        check_sync("UART_TX level", int'(uart_tx), 1);
        end_test("reset state", first_err);
        for (int i = 0; i < row_keys.size(); i++) begin
            @(posedge clk);
            #5;
            sw[6:0] = row_sw[i];
            key_n   = ~{4'b0000, row_keys[i]};
            repeat (4) @(posedge clk);
            #5 key_n = '1;
            repeat (4) @(posedge clk);
            @(negedge clk);
            first_err = errors;
            check_value("LED", led, row_exp[i]);
            end_test($sformatf("row %0d keys %b sw 0x%h", i, row_keys[i], row_sw[i]), first_err);
        end
        @(posedge clk);
        #5 sw[6:0] = 7'h6c;                     // Digits 4 and 5 read c and 6
        first_err = errors;
        for (int k = 1; k <= w_digit; k++) begin
            d         = k % w_digit;
            exp_digit = ~(w_digit'(1) << d);
            @(negedge clk);
            while (digit_n !== exp_digit) @(negedge clk);
            if (d < 4) nib = model[4 * d +: 4];
            else if (d == 4) nib = sw[3:0];
            else nib = {1'b0, sw[6:4]};
            check_segments($sformatf("ABCDEFGH digit %0d", d), abcdefgh, seg_ref[nib]);
        end
        end_test("digit scan", first_err);
        first_err = errors;
        measure_sync(0, low_len, period);
        check_sync("hsync low cycles", low_len, h_sync);
        check_sync("hsync period", period, h_total);
        measure_sync(1, low_len, period);
        check_sync("vsync low cycles", low_len, v_sync * h_total);
        check_sync("vsync period", period, v_total * h_total);
        end_test("sync timing", first_err);
        first_err = errors;
        scan_frame(model);
        end_test("color bars", first_err);
        $display("%0d tests, %0d failed, %0d check errors", n_tests, n_failed, errors);
        if (errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

/* flist.f */
source/board_pkg.sv
source/counter_control.sv
source/seven_segment_scan.sv
source/vga_display.sv
source/top.sv
source/board_specific_top.sv
test/tb_board_specific_top.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the board demo testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module tb_board_specific_top \
    -f flist.f -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi
echo "Simulation finished without failures"
